// File: list.f
rtl/notch_cfg_pkg.sv
rtl/cfg_access_ctrl.sv
rtl/notch_coeff_bank.sv
rtl/chain_ctrl_regs.sv
rtl/read_data_mux.sv
rtl/filter_cfg_top.sv
dv/filter_cfg_asserts.sv
dv/tb_filter_cfg.sv

// File: run.sh
#!/bin/sh
# Compile and run the register bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_filter_cfg -f list.f -o tb_filter_cfg_sim

# The simulator exits nonzero on a failure, the search below decides
out=$(./obj_dir/tb_filter_cfg_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    echo "Simulation passed"
else
    echo "Simulation did not pass"
    exit 1
fi

// File: dv/tb_filter_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_filter_cfg;
    import notch_cfg_pkg::*;

    localparam int NUM_RANDOM  = 400;
    localparam int NUM_TXN     = 3 * 21 + 4 + NUM_RANDOM;
    localparam int CLK_NS      = 4;
    localparam int WATCHDOG_NS = NUM_TXN * 3 * CLK_NS + 20 * CLK_NS + 200;
    localparam int SET_W       = $bits(coeff_set_t);

    logic       clk = 1'b0;
    logic       rst_n;
    logic       pwrite;
    logic       penable;
    addr_t      paddr;
    data_t      pwdata;
    region_en_t region_en;
    logic       pready;
    data_t      prdata;
    coeff_set_t notch_24_coeff;
    coeff_set_t notch_1_coeff;
    logic       notch_24_vld;
    logic       notch_1_vld;
    cic_r_t     cic_r;
    blk_on_t    blk_on;
    sel_t       out_sel;
    sel_t       coeff_sel;
    status_t    status;

    // Register map model and expected bus outputs
    coeff_set_t m_n24 = {20'h37061, 20'h5907c, 20'h37061, 20'h5907c, 20'h2e0c3};
    coeff_set_t m_n1  = {20'h37061, 20'hc8f9f, 20'h37061, 20'hc8f9f, 20'h2e0c3};
    cic_r_t     m_cic = 5'd1;
    blk_on_t    m_blk = '0;
    sel_t       m_out = '0;
    sel_t       m_csel = '0;
    status_t    m_status = '0;
    logic       exp_pready = 1'b0;
    logic       exp_vld24 = 1'b0;
    logic       exp_vld1 = 1'b0;
    data_t      exp_prdata = '0;

    logic [31:0] lfsr_state = 32'h4ebb;
    logic        run_done = 1'b0;
    logic        fail_seen = 1'b0;

    always #(CLK_NS / 2) clk = ~clk;

    filter_cfg_top i_dut (
        .clk (clk), .rst_n (rst_n), .pwrite (pwrite), .penable (penable),
        .paddr (paddr), .pwdata (pwdata), .region_en (region_en),
        .pready (pready), .prdata (prdata),
        .notch_24_coeff (notch_24_coeff), .notch_1_coeff (notch_1_coeff),
        .notch_24_vld (notch_24_vld), .notch_1_vld (notch_1_vld),
        .cic_r (cic_r), .blk_on (blk_on), .out_sel (out_sel),
        .coeff_sel (coeff_sel), .status (status)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus source and model helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic region_en_t correct_en(input addr_t a);
        region_en_t r;
        r = '0;
        if (a < CIC_R_ADDR) r.iir_en = 1'b1;
        else if (a == CIC_R_ADDR) r.cic_en = 1'b1;
        else r.ctrl_en = 1'b1;   // Also used for unmapped reads
        return r;
    endfunction

    function automatic logic write_allowed(input addr_t a, input region_en_t r);
        if ($countones(r) != 1) return 1'b0;
        if (r.iir_en) return a < CIC_R_ADDR;
        if (r.cic_en) return a == CIC_R_ADDR;
        return (a >= BLK_ON_BASE) && (a <= STATUS_ADDR);
    endfunction

    // b0 sits in the top bits of a set
    function automatic coeff_t pick_coeff(input coeff_set_t s, input int idx);
        logic [SET_W-1:0] sh;
        sh = s >> (COEFF_W * (NUM_COEFF - 1 - idx));
        return sh[COEFF_W-1:0];
    endfunction

    function automatic coeff_set_t set_coeff(input coeff_set_t s, input int idx, input coeff_t c);
        logic [SET_W-1:0] mask;
        logic [SET_W-1:0] val;
        int               sh;
        sh   = COEFF_W * (NUM_COEFF - 1 - idx);
        mask = {{(SET_W - COEFF_W){1'b0}}, {COEFF_W{1'b1}}} << sh;
        val  = {{(SET_W - COEFF_W){1'b0}}, c} << sh;
        return (s & ~mask) | val;
    endfunction

    function automatic data_t sext(input coeff_t c);
        return {{(DATA_W - COEFF_W){c[COEFF_W-1]}}, c};
    endfunction

    function automatic data_t expected_read(input addr_t a);
        int off;
        off = int'(a);
        if (a < NOTCH_1_BASE) return sext(pick_coeff(m_n24, off));
        if (a < CIC_R_ADDR) return sext(pick_coeff(m_n1, off - 5));
        if (a == CIC_R_ADDR) return data_t'(m_cic);
        if (a < OUT_SEL_ADDR) return data_t'((m_blk >> (off - 11)) & 5'd1);
        if (a == OUT_SEL_ADDR) return data_t'(m_out);
        if (a == COEFF_SEL_ADDR) return data_t'(m_csel);
        if (a == STATUS_ADDR) return data_t'(m_status);
        return 32'hAAAA_AAAA;
    endfunction

    task automatic apply_write(input addr_t a, input data_t d);
        int      off;
        blk_on_t bit_mask;
        off = int'(a);
        bit_mask = blk_on_t'(1) << (off - 11);
        if (a < NOTCH_1_BASE) begin
            m_n24 = set_coeff(m_n24, off, d[COEFF_W-1:0]);
            exp_vld24 = (off == NUM_COEFF - 1);
        end else if (a < CIC_R_ADDR) begin
            m_n1 = set_coeff(m_n1, off - 5, d[COEFF_W-1:0]);
            exp_vld1 = (off - 5 == NUM_COEFF - 1);
        end else if (a == CIC_R_ADDR) m_cic = d[4:0];
        else if (a < OUT_SEL_ADDR) m_blk = d[0] ? (m_blk | bit_mask) : (m_blk & ~bit_mask);
        else if (a == OUT_SEL_ADDR) m_out = d[1:0];
        else if (a == COEFF_SEL_ADDR) m_csel = d[1:0];
        else m_status = d[2:0];
    endtask

    // Applies the inputs seen at the rising edge to the model state before it
    task automatic model_edge();
        logic any_en;
        any_en = |region_en;
        exp_vld24 = 1'b0;
        exp_vld1  = 1'b0;
        if (!pwrite && !penable && any_en) exp_prdata = expected_read(paddr);
        else if (!pwrite) exp_prdata = '0;
        exp_pready = !penable && any_en;
        if (pwrite && penable && write_allowed(paddr, region_en)) apply_write(paddr, pwdata);
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic fail_stop();
        fail_seen = 1'b1;
        $display("Something failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_data(input string name, input data_t act, input data_t exp);
        if (act !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, act, exp);
            fail_stop();
        end
    endtask

    task automatic check_coeff_set(input string name, input coeff_set_t act, input coeff_set_t exp);
        if (act !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, act, exp);
            fail_stop();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, act, exp);
            fail_stop();
        end
    endtask

    task automatic check_cic(input string name, input cic_r_t act, input cic_r_t exp);
        if (act !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, act, exp);
            fail_stop();
        end
    endtask

    task automatic check_outputs();
        check_bit("pready", pready, exp_pready);
        check_data("prdata", prdata, exp_prdata);
        check_bit("notch_24_vld", notch_24_vld, exp_vld24);
        check_bit("notch_1_vld", notch_1_vld, exp_vld1);
        check_coeff_set("notch_24_coeff", notch_24_coeff, m_n24);
        check_coeff_set("notch_1_coeff", notch_1_coeff, m_n1);
        check_cic("cic_r", cic_r, m_cic);
        check_data("blk_on", data_t'(blk_on), data_t'(m_blk));
        check_data("out_sel", data_t'(out_sel), data_t'(m_out));
        check_data("coeff_sel", data_t'(coeff_sel), data_t'(m_csel));
        check_data("status", data_t'(status), data_t'(m_status));
    endtask

    ////////////////////////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////////////////////////
    task automatic clock_cycle(input logic nw, input logic ne, input addr_t na,
                               input data_t nd, input region_en_t nr);
        @(posedge clk);
        model_edge();
        #1;
        pwrite    = nw;
        penable   = ne;
        paddr     = na;
        pwdata    = nd;
        region_en = nr;
        @(negedge clk);
        check_outputs();
    endtask

    // Setup, access, then one idle cycle
    task automatic run_txn(input logic wr, input addr_t a, input data_t d, input region_en_t en);
        clock_cycle(wr, 1'b0, a, d, en);
        clock_cycle(wr, 1'b1, a, d, en);
        clock_cycle(1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic random_txn();
        logic [31:0] r;
        logic        wr;
        addr_t       a;
        data_t       d;
        region_en_t  en;
        r  = rand_bits(1);
        wr = r[0];
        a  = addr_t'(rand_bits(5) % 32'd21);
        d  = rand_bits(32);
        r  = rand_bits(7);
        if (r < 32'd115) begin
            en = correct_en(a);
        end else begin
            r  = rand_bits(3);   // Zero, wrong or several enables
            en = r[2:0];
        end
        run_txn(wr, a, d, en);
    endtask

    initial begin
        int a;
        int n;
        rst_n     = 1'b0;
        pwrite    = 1'b0;
        penable   = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        region_en = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_outputs();
        for (a = 0; a < 21; a++) run_txn(1'b0, addr_t'(a), '0, correct_en(addr_t'(a)));
        for (n = 0; n < NUM_RANDOM; n++) random_txn();
        // Blocked writes and a read with no enable
        run_txn(1'b1, 7'd4, 32'h000F_FFFF, '0);
        run_txn(1'b1, 7'd10, 32'h0000_001F, 3'b111);
        run_txn(1'b1, 7'd9, 32'h0001_2345, 3'b010);
        run_txn(1'b0, 7'd9, '0, '0);
        for (a = 0; a < 21; a++) run_txn(1'b1, addr_t'(a), rand_bits(32), correct_en(addr_t'(a)));
        for (a = 0; a < 21; a++) run_txn(1'b0, addr_t'(a), '0, correct_en(addr_t'(a)));
        run_done = 1'b1;
        $display("Everything OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_seen = 1'b1;
        $display("Watchdog expired before all transactions completed");
        $display("Something failed");
        $fatal(1, "Timeout");
    end

    final begin
        if (!run_done && !fail_seen) begin
            $display("Run ended before all transactions completed");
            $display("Something failed");
        end
    end

endmodule

`default_nettype wire

// File: dv/filter_cfg_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module filter_cfg_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      penable,
    input notch_cfg_pkg::region_en_t region_en,
    input logic                      pready,
    input notch_cfg_pkg::reg_wr_t    wr
);

    logic [6:0] stb;

    assign stb = {wr.notch_24_stb, wr.notch_1_stb, wr.cic_r_stb, wr.blk_on_stb,
                  wr.out_sel_stb, wr.coeff_sel_stb, wr.status_stb};

    ////////////////////////////////////////////////////////////
    // PREADY pulse
    ////////////////////////////////////////////////////////////
    pready_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        (!penable && (|region_en)) |=> pready)
        else $error("pready missing after an enabled setup cycle");

    pready_low_otherwise: assert property (@(posedge clk) disable iff (!rst_n)
        (penable || !(|region_en)) |=> !pready)
        else $error("pready high without an enabled setup cycle");

    // Write strobes
    single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(stb))
        else $error("more than one write strobe active");

    strobe_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        !penable |-> (stb == '0))   // Setup cycles never write
        else $error("write strobe active without penable");

endmodule

bind cfg_access_ctrl filter_cfg_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .penable   (penable),
    .region_en (region_en),
    .pready    (pready),
    .wr        (wr)
);

`default_nettype wire

// File: rtl/filter_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module filter_cfg_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pwrite,
    input  logic                       penable,
    input  notch_cfg_pkg::addr_t       paddr,
    input  notch_cfg_pkg::data_t       pwdata,
    input  notch_cfg_pkg::region_en_t  region_en,
    output logic                       pready,
    output notch_cfg_pkg::data_t       prdata,
    output notch_cfg_pkg::coeff_set_t  notch_24_coeff,
    output notch_cfg_pkg::coeff_set_t  notch_1_coeff,
    output logic                       notch_24_vld,
    output logic                       notch_1_vld,
    output notch_cfg_pkg::cic_r_t      cic_r,
    output notch_cfg_pkg::blk_on_t     blk_on,
    output notch_cfg_pkg::sel_t        out_sel,
    output notch_cfg_pkg::sel_t        coeff_sel,
    output notch_cfg_pkg::status_t     status
);
    import notch_cfg_pkg::*;

    reg_wr_t    wr;
    reg_sel_t   rd_sel;
    coeff_idx_t rd_idx;
    logic       rd_en;
    logic       rd_clr;

    ////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////
    cfg_access_ctrl u_access (
        .clk       (clk),
        .rst_n     (rst_n),
        .pwrite    (pwrite),
        .penable   (penable),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .region_en (region_en),
        .pready    (pready),
        .wr        (wr),
        .rd_sel    (rd_sel),
        .rd_idx    (rd_idx),
        .rd_en     (rd_en),
        .rd_clr    (rd_clr)
    );

    ////////////////////////////////////////////////////////////
    // Register storage
    ////////////////////////////////////////////////////////////
    notch_coeff_bank #(.RESET_SET(NOTCH_24_RESET)) u_notch_24 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_stb  (wr.notch_24_stb),
        .wr_idx  (wr.idx),
        .wr_data (wr.data[COEFF_W-1:0]),
        .coeff   (notch_24_coeff),
        .vld     (notch_24_vld)
    );

    notch_coeff_bank #(.RESET_SET(NOTCH_1_RESET)) u_notch_1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_stb  (wr.notch_1_stb),
        .wr_idx  (wr.idx),
        .wr_data (wr.data[COEFF_W-1:0]),
        .coeff   (notch_1_coeff),
        .vld     (notch_1_vld)
    );

    chain_ctrl_regs u_chain (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .cic_r     (cic_r),
        .blk_on    (blk_on),
        .out_sel   (out_sel),
        .coeff_sel (coeff_sel),
        .status    (status)
    );

    read_data_mux u_rdata (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_en          (rd_en),
        .rd_clr         (rd_clr),
        .rd_sel         (rd_sel),
        .rd_idx         (rd_idx),
        .notch_24_coeff (notch_24_coeff),
        .notch_1_coeff  (notch_1_coeff),
        .cic_r          (cic_r),
        .blk_on         (blk_on),
        .out_sel        (out_sel),
        .coeff_sel      (coeff_sel),
        .status         (status),
        .prdata         (prdata)
    );

endmodule

`default_nettype wire

// File: rtl/read_data_mux.sv
`timescale 1ns/1ps
`default_nettype none

module read_data_mux (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rd_en,
    input  logic                      rd_clr,
    input  notch_cfg_pkg::reg_sel_t   rd_sel,
    input  notch_cfg_pkg::coeff_idx_t rd_idx,
    input  notch_cfg_pkg::coeff_set_t notch_24_coeff,
    input  notch_cfg_pkg::coeff_set_t notch_1_coeff,
    input  notch_cfg_pkg::cic_r_t     cic_r,
    input  notch_cfg_pkg::blk_on_t    blk_on,
    input  notch_cfg_pkg::sel_t       out_sel,
    input  notch_cfg_pkg::sel_t       coeff_sel,
    input  notch_cfg_pkg::status_t    status,
    output notch_cfg_pkg::data_t      prdata
);
    import notch_cfg_pkg::*;

    coeff_t coeff_pick;
    data_t  rd_word;

    assign coeff_pick = (rd_sel == SEL_NOTCH_1) ? coeff_at(notch_1_coeff, rd_idx)
                                                : coeff_at(notch_24_coeff, rd_idx);

    always_comb begin
        case (rd_sel)
            SEL_NOTCH_24,
            SEL_NOTCH_1:   rd_word = {{(DATA_W - COEFF_W){coeff_pick[COEFF_W-1]}}, coeff_pick};
            SEL_CIC_R:     rd_word = data_t'(cic_r);
            SEL_BLK_ON:    rd_word = data_t'(blk_on[rd_idx]);
            SEL_OUT_SEL:   rd_word = data_t'(out_sel);
            SEL_COEFF_SEL: rd_word = data_t'(coeff_sel);
            SEL_STATUS:    rd_word = data_t'(status);
            default:       rd_word = UNMAPPED_PATTERN;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register holds through writes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata <= '0;
        end else if (rd_clr) begin
            prdata <= '0;
        end else if (rd_en) begin
            prdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: rtl/chain_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module chain_ctrl_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  notch_cfg_pkg::reg_wr_t wr,
    output notch_cfg_pkg::cic_r_t  cic_r,
    output notch_cfg_pkg::blk_on_t blk_on,
    output notch_cfg_pkg::sel_t    out_sel,
    output notch_cfg_pkg::sel_t    coeff_sel,
    output notch_cfg_pkg::status_t status
);
    import notch_cfg_pkg::*;

    ////////////////////////////////////////////////////////////
    // CIC decimation factor
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cic_r <= CIC_R_RESET;
        end else if (wr.cic_r_stb) begin
            cic_r <= wr.data[$bits(cic_r_t)-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // One block on/off bit per address
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_on <= '0;
        end else if (wr.blk_on_stb) begin
            blk_on[wr.blk_idx] <= wr.data[0];
        end
    end

    // Selects and status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_sel   <= '0;
            coeff_sel <= '0;
            status    <= '0;
        end else begin
            if (wr.out_sel_stb) begin
                out_sel <= wr.data[$bits(sel_t)-1:0];
            end
            if (wr.coeff_sel_stb) begin
                coeff_sel <= wr.data[$bits(sel_t)-1:0];   // Block whose coeffs are shown
            end
            if (wr.status_stb) begin
                status <= wr.data[$bits(status_t)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/notch_coeff_bank.sv
`timescale 1ns/1ps
`default_nettype none

module notch_coeff_bank #(
    parameter notch_cfg_pkg::coeff_set_t RESET_SET = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_stb,
    input  notch_cfg_pkg::coeff_idx_t wr_idx,
    input  notch_cfg_pkg::coeff_t     wr_data,
    output notch_cfg_pkg::coeff_set_t coeff,
    output logic                      vld
);
    import notch_cfg_pkg::*;

    localparam coeff_idx_t LAST_IDX = coeff_idx_t'(NUM_COEFF - 1);

    logic last_wr;

    assign last_wr = wr_stb && (wr_idx == LAST_IDX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coeff <= RESET_SET;
        end else if (wr_stb) begin
            case (wr_idx)
                3'd0: coeff.b0 <= wr_data;
                3'd1: coeff.b1 <= wr_data;
                3'd2: coeff.b2 <= wr_data;
                3'd3: coeff.a1 <= wr_data;
                3'd4: coeff.a2 <= wr_data;
                default: ;
            endcase
        end
    end

    // Set complete once a2 lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= 1'b0;
        end else begin
            vld <= last_wr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/cfg_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_access_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pwrite,
    input  logic                     penable,
    input  notch_cfg_pkg::addr_t     paddr,
    input  notch_cfg_pkg::data_t     pwdata,
    input  notch_cfg_pkg::region_en_t region_en,
    output logic                     pready,
    output notch_cfg_pkg::reg_wr_t   wr,
    output notch_cfg_pkg::reg_sel_t  rd_sel,
    output notch_cfg_pkg::coeff_idx_t rd_idx,
    output logic                     rd_en,
    output logic                     rd_clr
);
    import notch_cfg_pkg::*;

    logic  any_en;
    logic  region_ok;
    logic  in_iir;
    logic  in_cic;
    logic  in_ctrl;
    logic  wr_ok;
    addr_t offs;

    assign any_en    = |region_en;
    // Exactly one enable means odd parity and not all three
    assign region_ok = (region_en.iir_en ^ region_en.ctrl_en ^ region_en.cic_en) & ~(&region_en);

    assign in_iir  = paddr < CIC_R_ADDR;
    assign in_cic  = paddr == CIC_R_ADDR;
    assign in_ctrl = (paddr >= BLK_ON_BASE) && (paddr <= STATUS_ADDR);

    assign wr_ok = pwrite && penable && region_ok &&
                   ((region_en.iir_en  && in_iir) ||
                    (region_en.cic_en  && in_cic) ||
                    (region_en.ctrl_en && in_ctrl));

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        offs   = '0;
        rd_sel = SEL_UNMAPPED;
        if (paddr < NOTCH_1_BASE) begin
            rd_sel = SEL_NOTCH_24;
            offs   = paddr - NOTCH_24_BASE;
        end else if (paddr < CIC_R_ADDR) begin
            rd_sel = SEL_NOTCH_1;
            offs   = paddr - NOTCH_1_BASE;
        end else if (paddr == CIC_R_ADDR) begin
            rd_sel = SEL_CIC_R;
        end else if (paddr < OUT_SEL_ADDR) begin
            rd_sel = SEL_BLK_ON;
            offs   = paddr - BLK_ON_BASE;
        end else if (paddr == OUT_SEL_ADDR) begin
            rd_sel = SEL_OUT_SEL;
        end else if (paddr == COEFF_SEL_ADDR) begin
            rd_sel = SEL_COEFF_SEL;
        end else if (paddr == STATUS_ADDR) begin
            rd_sel = SEL_STATUS;
        end
    end

    assign rd_idx = offs[$bits(coeff_idx_t)-1:0];

    always_comb begin
        wr         = '0;
        wr.idx     = offs[$bits(coeff_idx_t)-1:0];
        wr.blk_idx = offs[2:0];
        wr.data    = pwdata;
        if (wr_ok) begin
            case (rd_sel)
                SEL_NOTCH_24:  wr.notch_24_stb  = 1'b1;
                SEL_NOTCH_1:   wr.notch_1_stb   = 1'b1;
                SEL_CIC_R:     wr.cic_r_stb     = 1'b1;
                SEL_BLK_ON:    wr.blk_on_stb    = 1'b1;
                SEL_OUT_SEL:   wr.out_sel_stb   = 1'b1;
                SEL_COEFF_SEL: wr.coeff_sel_stb = 1'b1;
                SEL_STATUS:    wr.status_stb    = 1'b1;
                default: ;
            endcase
        end
    end

    // Reads are answered in the setup cycle on any enable
    assign rd_en  = !pwrite && !penable && any_en;
    assign rd_clr = !pwrite && !rd_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready <= 1'b0;
        end else begin
            pready <= !penable && any_en;   // Pulse after setup
        end
    end

endmodule

`default_nettype wire

// File: rtl/notch_cfg_pkg.sv
`default_nettype none

package notch_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and types
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W    = 7;
    localparam int DATA_W    = 32;
    localparam int COEFF_W   = 20;   // S20.18
    localparam int NUM_COEFF = 5;

    typedef logic        [ADDR_W-1:0]  addr_t;
    typedef logic        [DATA_W-1:0]  data_t;
    typedef logic signed [COEFF_W-1:0] coeff_t;
    typedef logic        [2:0]         coeff_idx_t;
    typedef logic        [4:0]         cic_r_t;
    typedef logic        [4:0]         blk_on_t;   // [0] frac deci .. [4] FIR
    typedef logic        [1:0]         sel_t;
    typedef logic        [2:0]         status_t;

    typedef struct packed {
        coeff_t b0;
        coeff_t b1;
        coeff_t b2;
        coeff_t a1;
        coeff_t a2;
    } coeff_set_t;

    typedef struct packed {
        logic iir_en;
        logic ctrl_en;
        logic cic_en;
    } region_en_t;

    typedef enum logic [2:0] {
        SEL_NOTCH_24,
        SEL_NOTCH_1,
        SEL_CIC_R,
        SEL_BLK_ON,
        SEL_OUT_SEL,
        SEL_COEFF_SEL,
        SEL_STATUS,
        SEL_UNMAPPED
    } reg_sel_t;

    typedef struct packed {
        logic       notch_24_stb;
        logic       notch_1_stb;
        logic       cic_r_stb;
        logic       blk_on_stb;
        logic       out_sel_stb;
        logic       coeff_sel_stb;
        logic       status_stb;
        coeff_idx_t idx;        // Offset inside a notch bank
        logic [2:0] blk_idx;    // Which block on/off bit
        data_t      data;
    } reg_wr_t;

    ////////////////////////////////////////////////////////////
    // Address map and reset values
    ////////////////////////////////////////////////////////////
    localparam addr_t NOTCH_24_BASE  = 7'd0;
    localparam addr_t NOTCH_1_BASE   = 7'd5;
    localparam addr_t CIC_R_ADDR     = 7'd10;
    localparam addr_t BLK_ON_BASE    = 7'd11;
    localparam addr_t OUT_SEL_ADDR   = 7'd16;
    localparam addr_t COEFF_SEL_ADDR = 7'd17;
    localparam addr_t STATUS_ADDR    = 7'd18;

    localparam data_t UNMAPPED_PATTERN = 32'hAAAA_AAAA;

    localparam coeff_set_t NOTCH_24_RESET = '{b0: 20'sh37061, b1: 20'sh5907c, b2: 20'sh37061,
                                              a1: 20'sh5907c, a2: 20'sh2e0c3};
    localparam coeff_set_t NOTCH_1_RESET  = '{b0: 20'sh37061, b1: 20'shc8f9f, b2: 20'sh37061,
                                              a1: 20'shc8f9f, a2: 20'sh2e0c3};
    localparam cic_r_t     CIC_R_RESET    = 5'd1;

    // Coefficient at a bank offset, b0 first
    function automatic coeff_t coeff_at(input coeff_set_t set, input coeff_idx_t idx);
        case (idx)
            3'd0:    return set.b0;
            3'd1:    return set.b1;
            3'd2:    return set.b2;
            3'd3:    return set.a1;
            3'd4:    return set.a2;
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire
